//--- logic/rv_pkg.sv
package rv_pkg;

  // register and data width
  localparam int xlen = 32;

  // register values and instruction words
  typedef logic [xlen-1:0] word_t;

  // register index into the architectural file
  typedef logic [4:0] reg_addr_t;

  // major opcodes of the kept instructions
  localparam logic [6:0] op_lui     = 7'b01_101_11;
  localparam logic [6:0] op_reg_imm = 7'b00_100_11;
  localparam logic [6:0] op_reg_reg = 7'b01_100_11;
  localparam logic [6:0] op_system  = 7'b11_100_11;

  // funct3 values shared by the immediate and register forms
  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_xor = 3'b100;
  localparam logic [2:0] f3_or  = 3'b110;
  localparam logic [2:0] f3_and = 3'b111;

  // funct7 values for the register-register group
  localparam logic [6:0] f7_base = 7'b000_0000;
  localparam logic [6:0] f7_sub  = 7'b010_0000;

  // only exact encoding of ecall, every other field zero
  localparam word_t ecall_word = 32'h0000_0073;

  // alu operations, pass_b serves lui
  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_xor,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  // decoded instruction as handed from decode to execute
  typedef struct packed {
    logic      valid;
    word_t     insn;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    // already qualified by valid and rd != 0
    logic      writes_rd;
    // second alu operand from imm instead of rs2
    logic      uses_imm;
    // sign-extended i-type or upper-shifted u-type
    word_t     imm;
    alu_op_e   alu_op;
    logic      is_ecall;
  } uop_t;

endpackage

//--- logic/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile #(
  parameter int reg_count = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1_addr,
  input  rv_pkg::reg_addr_t rs2_addr,
  input  logic              wr_en,
  input  rv_pkg::reg_addr_t wr_addr,
  input  rv_pkg::word_t     wr_data,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data
);

  rv_pkg::word_t regs [reg_count];

  // write at the edge
  // wr_en never arrives for x0, so entry zero keeps its reset value
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // combinational reads
  // same-cycle retire write wins over the stored value
  assign rs1_data = (wr_en && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
  assign rs2_data = (wr_en && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

endmodule

//--- logic/rv_decode_stage.sv
`timescale 1ns/1ps

module rv_decode_stage (
  input  logic              clk,
  input  logic              rst,
  input  logic              insn_valid,
  input  rv_pkg::word_t     insn,
  input  rv_pkg::word_t     rs1_data,
  input  rv_pkg::word_t     rs2_data,
  output logic              insn_ready,
  output rv_pkg::reg_addr_t rs1_addr,
  output rv_pkg::reg_addr_t rs2_addr,
  output rv_pkg::uop_t      dx_uop,
  output rv_pkg::word_t     rs1_val,
  output rv_pkg::word_t     rs2_val
);

  logic          accept;
  logic          dr_valid;
  rv_pkg::word_t dr_insn;

  logic [6:0]        opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  rv_pkg::reg_addr_t rd;
  rv_pkg::word_t     imm_i;
  rv_pkg::word_t     imm_u;
  // word is one of the kept arithmetic forms or lui
  logic              known;

  assign accept = insn_valid && insn_ready;

  // decode register valid and input handshake
  // ready drops for good once ecall is taken in
  always_ff @(posedge clk) begin
    if (rst) begin
      dr_valid   <= 1'b0;
      insn_ready <= 1'b1;
    end else begin
      dr_valid <= accept;
      if (accept && insn == rv_pkg::ecall_word) begin
        insn_ready <= 1'b0;
      end
    end
  end

  // instruction word, only meaningful with dr_valid
  always_ff @(posedge clk) begin
    if (accept) begin
      dr_insn <= insn;
    end
  end

  // field split
  assign opcode = dr_insn[6:0];
  assign rd     = dr_insn[11:7];
  assign funct3 = dr_insn[14:12];
  assign funct7 = dr_insn[31:25];

  // i-type sign extended, u-type placed in the upper 20 bits
  assign imm_i = {{20{dr_insn[31]}}, dr_insn[31:20]};
  assign imm_u = {dr_insn[31:12], 12'b0};

  // register file read straight from the source fields
  // lui and i-type read junk here, execute ignores it
  assign rs1_addr = dr_insn[19:15];
  assign rs2_addr = dr_insn[24:20];
  assign rs1_val  = rs1_data;
  assign rs2_val  = rs2_data;

  always_comb begin
    known         = 1'b0;
    dx_uop        = '0;
    dx_uop.valid  = dr_valid;
    dx_uop.insn   = dr_insn;
    dx_uop.rd     = rd;
    dx_uop.rs1    = rs1_addr;
    dx_uop.rs2    = rs2_addr;
    dx_uop.imm    = imm_i;
    dx_uop.alu_op = rv_pkg::alu_add;
    case (opcode)
      rv_pkg::op_lui: begin
        known           = 1'b1;
        dx_uop.uses_imm = 1'b1;
        dx_uop.imm      = imm_u;
        dx_uop.alu_op   = rv_pkg::alu_pass_b;
      end
      rv_pkg::op_reg_imm: begin
        known           = 1'b1;
        dx_uop.uses_imm = 1'b1;
        case (funct3)
          rv_pkg::f3_add: dx_uop.alu_op = rv_pkg::alu_add;
          rv_pkg::f3_xor: dx_uop.alu_op = rv_pkg::alu_xor;
          rv_pkg::f3_or:  dx_uop.alu_op = rv_pkg::alu_or;
          rv_pkg::f3_and: dx_uop.alu_op = rv_pkg::alu_and;
          // shifts and compares fall through as no-ops
          default:        known = 1'b0;
        endcase
      end
      rv_pkg::op_reg_reg: begin
        known = 1'b1;
        if (funct7 == rv_pkg::f7_sub && funct3 == rv_pkg::f3_add) begin
          dx_uop.alu_op = rv_pkg::alu_sub;
        end else if (funct7 == rv_pkg::f7_base) begin
          case (funct3)
            rv_pkg::f3_add: dx_uop.alu_op = rv_pkg::alu_add;
            rv_pkg::f3_xor: dx_uop.alu_op = rv_pkg::alu_xor;
            rv_pkg::f3_or:  dx_uop.alu_op = rv_pkg::alu_or;
            rv_pkg::f3_and: dx_uop.alu_op = rv_pkg::alu_and;
            default:        known = 1'b0;
          endcase
        end else begin
          // mul/div and other funct7 values
          known = 1'b0;
        end
      end
      rv_pkg::op_system: begin
        dx_uop.is_ecall = dr_valid && dr_insn == rv_pkg::ecall_word;
      end
      default: begin
        known = 1'b0;
      end
    endcase
    // x0 destination never writes, so no later stage checks rd again
    dx_uop.writes_rd = dr_valid && known && rd != '0;
  end

endmodule

//--- logic/rv_execute_stage.sv
`timescale 1ns/1ps

module rv_execute_stage (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::uop_t      dx_uop,
  input  rv_pkg::word_t     rs1_val,
  input  rv_pkg::word_t     rs2_val,
  input  logic              w_valid,
  input  rv_pkg::reg_addr_t w_rd,
  input  logic              w_writes_rd,
  input  rv_pkg::word_t     w_result,
  output logic              m_valid,
  output rv_pkg::word_t     m_insn,
  output rv_pkg::reg_addr_t m_rd,
  output logic              m_writes_rd,
  output rv_pkg::word_t     m_result,
  output logic              m_is_ecall
);

  rv_pkg::uop_t  ex_uop;
  rv_pkg::word_t ex_rs1_val;
  rv_pkg::word_t ex_rs2_val;
  rv_pkg::word_t op_a;
  rv_pkg::word_t rs2_fwd;
  rv_pkg::word_t op_b;
  rv_pkg::word_t alu_out;

  // execute register, cleared so no stale valid survives reset
  always_ff @(posedge clk) begin
    if (rst) begin
      ex_uop <= '0;
    end else begin
      ex_uop <= dx_uop;
    end
  end

  // operand values as read in decode
  always_ff @(posedge clk) begin
    ex_rs1_val <= rs1_val;
    ex_rs2_val <= rs2_val;
  end

  // forwarding, memory stage is younger so it goes first
  always_comb begin
    if (m_valid && m_writes_rd && m_rd == ex_uop.rs1) begin
      op_a = m_result;
    end else if (w_valid && w_writes_rd && w_rd == ex_uop.rs1) begin
      op_a = w_result;
    end else begin
      op_a = ex_rs1_val;
    end
    if (m_valid && m_writes_rd && m_rd == ex_uop.rs2) begin
      rs2_fwd = m_result;
    end else if (w_valid && w_writes_rd && w_rd == ex_uop.rs2) begin
      rs2_fwd = w_result;
    end else begin
      rs2_fwd = ex_rs2_val;
    end
  end

  // immediate forms take imm as second operand
  assign op_b = ex_uop.uses_imm ? ex_uop.imm : rs2_fwd;

  always_comb begin
    case (ex_uop.alu_op)
      rv_pkg::alu_add:    alu_out = op_a + op_b;
      rv_pkg::alu_sub:    alu_out = op_a - op_b;
      rv_pkg::alu_xor:    alu_out = op_a ^ op_b;
      rv_pkg::alu_or:     alu_out = op_a | op_b;
      rv_pkg::alu_and:    alu_out = op_a & op_b;
      // lui result is the shifted immediate
      rv_pkg::alu_pass_b: alu_out = op_b;
      default:            alu_out = op_a + op_b;
    endcase
  end

  // memory-stage register, only carries the result onward
  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid     <= 1'b0;
      m_writes_rd <= 1'b0;
      m_is_ecall  <= 1'b0;
    end else begin
      m_valid     <= ex_uop.valid;
      m_writes_rd <= ex_uop.writes_rd;
      m_is_ecall  <= ex_uop.is_ecall;
    end
  end

  always_ff @(posedge clk) begin
    m_insn   <= ex_uop.insn;
    m_rd     <= ex_uop.rd;
    m_result <= alu_out;
  end

endmodule

//--- logic/rv_retire_stage.sv
`timescale 1ns/1ps

module rv_retire_stage (
  input  logic              clk,
  input  logic              rst,
  input  logic              m_valid,
  input  rv_pkg::word_t     m_insn,
  input  rv_pkg::reg_addr_t m_rd,
  input  logic              m_writes_rd,
  input  rv_pkg::word_t     m_result,
  input  logic              m_is_ecall,
  output logic              w_valid,
  output rv_pkg::reg_addr_t w_rd,
  output logic              w_writes_rd,
  output rv_pkg::word_t     w_result,
  output logic              retire_valid,
  output rv_pkg::word_t     retire_insn,
  output rv_pkg::reg_addr_t retire_rd,
  output logic              retire_we,
  output rv_pkg::word_t     retire_data,
  output logic              halt
);

  rv_pkg::word_t w_insn;

  // retire register control bits
  // halt set on the same edge the ecall enters, then sticks
  always_ff @(posedge clk) begin
    if (rst) begin
      w_valid     <= 1'b0;
      w_writes_rd <= 1'b0;
      halt        <= 1'b0;
    end else begin
      w_valid     <= m_valid;
      w_writes_rd <= m_writes_rd;
      halt        <= halt || (m_valid && m_is_ecall);
    end
  end

  always_ff @(posedge clk) begin
    w_insn   <= m_insn;
    w_rd     <= m_rd;
    w_result <= m_result;
  end

  // trace view of the retire register
  // data shown even for non-writing instructions
  assign retire_valid = w_valid;
  assign retire_insn  = w_insn;
  assign retire_rd    = w_rd;
  assign retire_we    = w_writes_rd;
  assign retire_data  = w_result;

endmodule

//--- logic/rv_pipeline_top.sv
`timescale 1ns/1ps

module rv_pipeline_top #(
  parameter int reg_count = 32
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              insn_valid,
  input  rv_pkg::word_t     insn,
  output logic              insn_ready,
  output logic              retire_valid,
  output rv_pkg::word_t     retire_insn,
  output rv_pkg::reg_addr_t retire_rd,
  output logic              retire_we,
  output rv_pkg::word_t     retire_data,
  output logic              halt
);

  // register file read port
  rv_pkg::reg_addr_t rs1_addr;
  rv_pkg::reg_addr_t rs2_addr;
  rv_pkg::word_t     rs1_data;
  rv_pkg::word_t     rs2_data;

  // decode to execute
  rv_pkg::uop_t  dx_uop;
  rv_pkg::word_t rs1_val;
  rv_pkg::word_t rs2_val;

  // memory-stage register
  logic              m_valid;
  rv_pkg::word_t     m_insn;
  rv_pkg::reg_addr_t m_rd;
  logic              m_writes_rd;
  rv_pkg::word_t     m_result;
  logic              m_is_ecall;

  // retire register, doubles as write port and forwarding source
  logic              w_valid;
  rv_pkg::reg_addr_t w_rd;
  logic              w_writes_rd;
  rv_pkg::word_t     w_result;

  rv_decode_stage decode (
    .clk        (clk),
    .rst        (rst),
    .insn_valid (insn_valid),
    .insn       (insn),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .insn_ready (insn_ready),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .dx_uop     (dx_uop),
    .rs1_val    (rs1_val),
    .rs2_val    (rs2_val)
  );

  rv_execute_stage execute (
    .clk         (clk),
    .rst         (rst),
    .dx_uop      (dx_uop),
    .rs1_val     (rs1_val),
    .rs2_val     (rs2_val),
    .w_valid     (w_valid),
    .w_rd        (w_rd),
    .w_writes_rd (w_writes_rd),
    .w_result    (w_result),
    .m_valid     (m_valid),
    .m_insn      (m_insn),
    .m_rd        (m_rd),
    .m_writes_rd (m_writes_rd),
    .m_result    (m_result),
    .m_is_ecall  (m_is_ecall)
  );

  rv_retire_stage retire (
    .clk          (clk),
    .rst          (rst),
    .m_valid      (m_valid),
    .m_insn       (m_insn),
    .m_rd         (m_rd),
    .m_writes_rd  (m_writes_rd),
    .m_result     (m_result),
    .m_is_ecall   (m_is_ecall),
    .w_valid      (w_valid),
    .w_rd         (w_rd),
    .w_writes_rd  (w_writes_rd),
    .w_result     (w_result),
    .retire_valid (retire_valid),
    .retire_insn  (retire_insn),
    .retire_rd    (retire_rd),
    .retire_we    (retire_we),
    .retire_data  (retire_data),
    .halt         (halt)
  );

  // writes_rd already implies a valid instruction
  rv_regfile #(
    .reg_count (reg_count)
  ) rf (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .wr_en    (w_writes_rd),
    .wr_addr  (w_rd),
    .wr_data  (w_result),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

endmodule

//--- bench/tb_rv_pipeline.sv
`timescale 1ns/1ps

module tb_rv_pipeline;

  // lfsr seed and taps for x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] lfsr_seed = 32'd83612;
  localparam logic [31:0] lfsr_taps = 32'h8020_0003;
  // wait limits in cycles
  localparam int ready_timeout  = 50;
  localparam int retire_timeout = 50;
  localparam int halt_timeout   = 10;
  localparam int quiet_cycles   = 20;
  // leading records go in back to back for forwarding and bypass
  localparam int burst_records  = 11;
  localparam int max_words      = 256;
  localparam string golden_file = "bench/rv_golden.txt";
  localparam logic [31:0] end_marker = 32'hffff_ffff;

  logic              clk;
  logic              rst;
  logic              insn_valid;
  rv_pkg::word_t     insn;
  logic              insn_ready;
  logic              retire_valid;
  rv_pkg::word_t     retire_insn;
  rv_pkg::reg_addr_t retire_rd;
  logic              retire_we;
  rv_pkg::word_t     retire_data;
  logic              halt;

  // four words per record as insn, rd, we and result
  logic [31:0] golden [max_words];
  int          record_count;
  int          check_count;
  int          error_count;
  logic        run_broken;
  logic [31:0] lfsr_state;

  rv_pipeline_top #(
    .reg_count (32)
  ) uut (
    .clk          (clk),
    .rst          (rst),
    .insn_valid   (insn_valid),
    .insn         (insn),
    .insn_ready   (insn_ready),
    .retire_valid (retire_valid),
    .retire_insn  (retire_insn),
    .retire_rd    (retire_rd),
    .retire_we    (retire_we),
    .retire_data  (retire_data),
    .halt         (halt)
  );

  always #5 clk = ~clk;

  // galois form shifting right and folding in the taps on a one
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] shifted;
    shifted = state >> 1;
    if (state[0]) begin
      shifted = shifted ^ lfsr_taps;
    end
    return shifted;
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int width, output int value);
    value = 0;
    for (int i = 0; i < width; i++) begin
      value = (value << 1) | lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic check_word(input string test_name, input logic [31:0] expected,
                            input logic [31:0] actual);
    check_count++;
    assert (actual === expected) else begin
      error_count++;
      $display("error %s: expected %h, actual %h", test_name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    run_broken = 1'b1;
    $display("%s", what);
  endtask

  // records up to the end marker
  task automatic count_records();
    logic found;
    found = 1'b0;
    record_count = 0;
    for (int i = 0; i < max_words / 4 && !found; i++) begin
      if (golden[4 * i] === end_marker) begin
        found = 1'b1;
      end else begin
        record_count++;
      end
    end
    if (!found) begin
      record_count = 0;
      report_failure("golden file is missing or has no end marker");
    end
  endtask

  task automatic send_record(input int idx);
    int   gap;
    int   gap_on;
    int   waited;
    logic taken;
    gap = 0;
    if (idx >= burst_records) begin
      draw_bits(1, gap_on);
      if (gap_on != 0) begin
        draw_bits(2, gap);
        gap = gap + 1;
      end
    end
    // bubble cycles with valid held low
    insn_valid = 1'b0;
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    insn_valid = 1'b1;
    insn       = golden[4 * idx];
    taken      = 1'b0;
    waited     = 0;
    // ready is a register output and stable between edges
    while (!taken && !run_broken) begin
      taken = insn_ready;
      @(posedge clk);
      #1;
      waited++;
      if (!taken && waited > ready_timeout) begin
        report_failure($sformatf("insn_ready never rose for record %0d", idx));
      end
    end
    insn_valid = 1'b0;
  endtask

  task automatic drive_all();
    for (int idx = 0; idx < record_count && !run_broken; idx++) begin
      send_record(idx);
    end
    // ecall taken so the input closes
    if (!run_broken) begin
      check_word("ready after ecall", 32'd0, {31'b0, insn_ready});
      // a writing word stays on offer behind the ecall
      insn_valid = 1'b1;
      insn       = golden[0];
    end
  endtask

  // in-order trace compare sampled on the falling edge
  task automatic watch_retires();
    int          waited;
    string       name;
    logic [31:0] expect_halt;
    for (int idx = 0; idx < record_count && !run_broken; idx++) begin
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
      end while (!retire_valid && !run_broken && waited < retire_timeout);
      if (!retire_valid && !run_broken) begin
        report_failure($sformatf("record %0d never retired", idx));
      end else if (retire_valid) begin
        name = $sformatf("record %0d", idx);
        expect_halt = (idx == record_count - 1) ? 32'd1 : 32'd0;
        check_word({name, " insn"}, golden[4 * idx], retire_insn);
        check_word({name, " rd"}, golden[4 * idx + 1], {27'b0, retire_rd});
        check_word({name, " we"}, golden[4 * idx + 2], {31'b0, retire_we});
        // result only defined for writing instructions
        if (golden[4 * idx + 2][0]) begin
          check_word({name, " data"}, golden[4 * idx + 3], retire_data);
        end
        // halt comes with the ecall retire only
        check_word({name, " halt"}, expect_halt, {31'b0, halt});
      end
    end
  endtask

  // halt sticks and the trace stays empty
  task automatic check_halt_hold();
    int waited;
    waited = 0;
    while (!halt && !run_broken) begin
      @(negedge clk);
      waited++;
      if (!halt && waited > halt_timeout) begin
        report_failure("halt never rose after the ecall");
      end
    end
    repeat (quiet_cycles) begin
      @(negedge clk);
      check_word("halt hold", 32'd1, {31'b0, halt});
      check_word("retire after halt", 32'd0, {31'b0, retire_valid});
    end
  endtask

  task automatic finish_run();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    insn_valid  = 1'b0;
    insn        = '0;
    check_count = 0;
    error_count = 0;
    run_broken  = 1'b0;
    lfsr_state  = lfsr_seed;
    $readmemh(golden_file, golden);
    count_records();
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    // state straight out of reset
    check_word("reset retire_valid", 32'd0, {31'b0, retire_valid});
    check_word("reset retire_we", 32'd0, {31'b0, retire_we});
    check_word("reset halt", 32'd0, {31'b0, halt});
    check_word("reset insn_ready", 32'd1, {31'b0, insn_ready});
    fork
      drive_all();
      watch_retires();
    join
    if (!run_broken) begin
      check_halt_hold();
    end
    finish_run();
  end

endmodule

//--- bench/rv_golden.txt
// columns: instruction word, expected rd, expected write enable, expected result
// result checked only where write enable is 1, ffffffff in the first column ends the list
00500093 01 1 00000005  // addi x1, x0, 5
ffd08113 02 1 00000002  // addi x2, x1, -3
002081b3 03 1 00000007  // add x3, x1, x2, both operands forwarded
40118233 04 1 00000002  // sub x4, x3, x1
123452b7 05 1 12345000  // lui x5, 0x12345
6782e313 06 1 12345678  // ori x6, x5, 0x678
fff34393 07 1 edcba987  // xori x7, x6, -1
0f03f413 08 1 00000080  // andi x8, x7, 0xf0
06408013 00 0 00000000  // addi x0, x1, 100, no write
007344b3 09 1 ffffffff  // xor x9, x6, x7
00806533 0a 1 00000080  // or x10, x0, x8, x8 through register file bypass
0054f5b3 0b 1 12345000  // and x11, x9, x5
00309613 0c 0 00000000  // slli x12, x1, 3, dropped so no-op
004606b3 0d 1 00000002  // add x13, x12, x4
40d00733 0e 1 fffffffe  // sub x14, x0, x13
80070793 0f 1 fffff7fe  // addi x15, x14, -2048
00e78833 10 1 fffff7fc  // add x16, x15, x14
00000073 00 0 00000000  // ecall
ffffffff 00 0 00000000  // end marker

//--- src.f
logic/rv_pkg.sv
logic/rv_regfile.sv
logic/rv_decode_stage.sv
logic/rv_execute_stage.sv
logic/rv_retire_stage.sv
logic/rv_pipeline_top.sv
bench/tb_rv_pipeline.sv
